/* design/uartPkg.sv */
`default_nettype none

package uartPkg;

	//////////////////////////////
	// serial frame
	//////////////////////////////

	localparam int dataBits = 8;      // payload bits per frame
	localparam int overSample = 16;   // ticks per bit
	localparam int stopTicks = 16;    // single stop bit

	//////////////////////////////
	// register map
	//////////////////////////////

	// byte offsets, sized to the bus address
	typedef enum logic [3:0]
	{
		regData = 4'h0,     // rx pop on read, tx push on write
		regStatus = 4'h4,   // read only
		regClear = 4'h8     // any write drops the overrun flag
	} regOffset_t;

	// flags of one fifo
	typedef struct packed
	{
		logic empty;
		logic full;
	} fifoStatus_t;

	// low bits of the status word
	typedef struct packed
	{
		logic rxEmpty;
		logic rxFull;
		logic txEmpty;
		logic txFull;
		logic rxOverrun;    // sticky
	} uartStatus_t;

endpackage

`default_nettype wire

/* design/axiLitePkg.sv */
`default_nettype none

package axiLitePkg;

	localparam int addrLen = 4;   // 16 bytes of register space

	typedef enum logic [1:0]
	{
		respOkay = 2'b00,
		respSlvErr = 2'b10
	} axiResp_t;

	// master to slave
	typedef struct packed
	{
		logic awValid;
		logic [addrLen-1:0] awAddr;
		logic wValid;
		logic [31:0] wData;
		logic [3:0] wStrb;
		logic bReady;
		logic arValid;
		logic [addrLen-1:0] arAddr;
		logic rReady;
	} axiLiteReq_t;

	// slave to master
	typedef struct packed
	{
		logic awReady;
		logic wReady;
		logic bValid;
		axiResp_t bResp;
		logic arReady;
		logic rValid;
		logic [31:0] rData;
		axiResp_t rResp;
	} axiLiteRsp_t;

endpackage

`default_nettype wire

/* design/baudTickGen.sv */
`timescale 1ns/100ps
`default_nettype none

// one-cycle tick every baudDivisor clocks, 16x the bit rate
module baudTickGen
#(
	parameter int baudDivisor = 4
)
(
	input logic clk,
	input logic reset,
	output logic sTick
);

	localparam int cntLen = (baudDivisor > 1) ? $clog2(baudDivisor) : 1;

	logic [cntLen-1:0] divCnt;   // clocks since last tick
	logic wrap;

	assign wrap = (divCnt == cntLen'(baudDivisor - 1));

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			divCnt <= '0;
		else if (wrap)
			divCnt <= '0;      // restart period
		else
			divCnt <= divCnt + 1'b1;
	end

	assign sTick = wrap;   // high for the last clock of each period

	// ticks stay apart unless the divisor is 1
	assert property (@(posedge clk) disable iff (reset)
		(baudDivisor > 1) && sTick |=> !sTick);

endmodule

`default_nettype wire

/* design/uartRec.sv */
`timescale 1ns/100ps
`default_nettype none

// oversampling receiver, 8N1, LSB first
module uartRec
(
	input logic clk,
	input logic reset,
	input logic sTick,     // 16x oversampling tick
	input logic rx,        // serial in, idles high
	output logic rxDoneTick,
	output logic [uartPkg::dataBits-1:0] dOut
);

	localparam int midTicks = uartPkg::overSample / 2;
	localparam int maxTicks = (uartPkg::stopTicks > uartPkg::overSample) ?
		uartPkg::stopTicks : uartPkg::overSample;
	localparam int cntLen = $clog2(maxTicks);
	localparam int bitLen = $clog2(uartPkg::dataBits);

	typedef enum logic [1:0] {idle, start, data, stop} state_t;

	state_t stateReg;
	logic [cntLen-1:0] sReg;                 // ticks into current bit
	logic [bitLen-1:0] nReg;                 // data bits taken so far
	logic [uartPkg::dataBits-1:0] bReg;      // incoming byte
	logic bitDone;                           // middle of the next data bit

	assign bitDone = sTick && (sReg == cntLen'(uartPkg::overSample - 1));

	//////////////////////////////
	// control
	//////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= idle;
			sReg <= '0;
			nReg <= '0;
			rxDoneTick <= 1'b0;
		end
		else
		begin
			rxDoneTick <= 1'b0;   // single clock pulse
			case (stateReg)
				idle:
					if (!rx)   // start bit edge
					begin
						stateReg <= start;
						sReg <= '0;
					end
				start:
					if (sTick)
					begin
						if (sReg == cntLen'(midTicks - 1))   // middle of start bit
						begin
							stateReg <= data;
							sReg <= '0;
							nReg <= '0;
						end
						else
							sReg <= sReg + 1'b1;
					end
				data:
					if (bitDone)
					begin
						sReg <= '0;
						if (nReg == bitLen'(uartPkg::dataBits - 1))
							stateReg <= stop;   // last data bit taken
						else
							nReg <= nReg + 1'b1;
					end
					else if (sTick)
						sReg <= sReg + 1'b1;
				stop:
					if (sTick)
					begin
						if (sReg == cntLen'(uartPkg::stopTicks - 1))
						begin
							stateReg <= idle;
							rxDoneTick <= 1'b1;   // byte ready on dOut
						end
						else
							sReg <= sReg + 1'b1;
					end
				default:
					stateReg <= idle;
			endcase
		end
	end

	//////////////////////////////
	// data path
	//////////////////////////////

	// bits enter at the top and walk down, LSB first on the line
	always_ff @(posedge clk)
	begin
		if ((stateReg == data) && bitDone)
			bReg <= {rx, bReg[uartPkg::dataBits-1:1]};
	end

	assign dOut = bReg;

	// done only right after the final stop tick
	assert property (@(posedge clk) disable iff (reset)
		rxDoneTick |-> $past(sTick) && ($past(stateReg) == stop));

endmodule

`default_nettype wire

/* design/uartXmit.sv */
`timescale 1ns/100ps
`default_nettype none

// transmitter, same frame as the receiver
module uartXmit
(
	input logic clk,
	input logic reset,
	input logic sTick,
	input logic txStart,                         // tx fifo holds a byte
	input logic [uartPkg::dataBits-1:0] txData,  // fifo head
	output logic txReady,
	output logic txPop,
	output logic tx
);

	localparam int maxTicks = (uartPkg::stopTicks > uartPkg::overSample) ?
		uartPkg::stopTicks : uartPkg::overSample;
	localparam int cntLen = $clog2(maxTicks);
	localparam int bitLen = $clog2(uartPkg::dataBits);

	typedef enum logic [1:0] {idle, start, data, stop} state_t;

	state_t stateReg;
	logic [cntLen-1:0] sReg;                 // ticks into current bit
	logic [bitLen-1:0] nReg;                 // data bits sent
	logic [uartPkg::dataBits-1:0] bReg;      // outgoing byte, shifts right
	logic bitDone;                           // end of a full bit time

	assign bitDone = sTick && (sReg == cntLen'(uartPkg::overSample - 1));
	assign txReady = (stateReg == idle);
	assign txPop = txReady && txStart;   // head taken on this edge

	//////////////////////////////
	// control and line
	//////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= idle;
			sReg <= '0;
			nReg <= '0;
			tx <= 1'b1;   // line idle
		end
		else
		begin
			case (stateReg)
				idle:
					if (txStart)
					begin
						stateReg <= start;
						sReg <= '0;
						tx <= 1'b0;   // start bit
					end
				start:
					if (bitDone)
					begin
						stateReg <= data;
						sReg <= '0;
						nReg <= '0;
						tx <= bReg[0];
					end
					else if (sTick)
						sReg <= sReg + 1'b1;
				data:
					if (bitDone)
					begin
						sReg <= '0;
						if (nReg == bitLen'(uartPkg::dataBits - 1))
						begin
							stateReg <= stop;
							tx <= 1'b1;   // stop bit
						end
						else
						begin
							nReg <= nReg + 1'b1;
							tx <= bReg[1];   // next bit, before the shift lands
						end
					end
					else if (sTick)
						sReg <= sReg + 1'b1;
				stop:
					if (sTick)
					begin
						if (sReg == cntLen'(uartPkg::stopTicks - 1))
							stateReg <= idle;
						else
							sReg <= sReg + 1'b1;
					end
				default:
					stateReg <= idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (txPop)
			bReg <= txData;
		else if ((stateReg == data) && bitDone)
			bReg <= bReg >> 1;
	end

	// line high while idle, start bit right after a pop
	assert property (@(posedge clk) disable iff (reset) (stateReg == idle) |-> tx);
	assert property (@(posedge clk) disable iff (reset) txPop |=> !tx);

endmodule

`default_nettype wire

/* design/uartFifo.sv */
`timescale 1ns/100ps
`default_nettype none

// circular buffer, one extra pointer bit tells full from empty
module uartFifo
#(
	parameter int fifoDepth = 16   // power of two
)
(
	input logic clk,
	input logic reset,
	input logic push,
	input logic pop,
	input logic [uartPkg::dataBits-1:0] pushData,
	output logic [uartPkg::dataBits-1:0] headData,
	output uartPkg::fifoStatus_t status
);

	localparam int ptrLen = $clog2(fifoDepth);

	logic [uartPkg::dataBits-1:0] mem [fifoDepth];
	logic [ptrLen:0] wrPtr;   // msb is the wrap bit
	logic [ptrLen:0] rdPtr;
	logic doPush;
	logic doPop;

	assign status.empty = (wrPtr == rdPtr);
	assign status.full = (wrPtr[ptrLen] != rdPtr[ptrLen]) &&
		(wrPtr[ptrLen-1:0] == rdPtr[ptrLen-1:0]);   // one lap ahead

	assign doPush = push && !status.full;   // drop on full
	assign doPop = pop && !status.empty;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr[ptrLen-1:0]] <= pushData;
	end

	assign headData = mem[rdPtr[ptrLen-1:0]];   // first-word fall-through

	// users check empty before they pop
	assert property (@(posedge clk) disable iff (reset) pop |-> !status.empty);

endmodule

`default_nettype wire

/* design/uartAxiRegs.sv */
`timescale 1ns/100ps
`default_nettype none

// AXI4-Lite slave over the rx/tx fifos
module uartAxiRegs
(
	input logic clk,
	input logic reset,
	input logic rxDone,                              // receiver done pulse
	input axiLitePkg::axiLiteReq_t busReq,
	output axiLitePkg::axiLiteRsp_t busRsp,
	input logic [uartPkg::dataBits-1:0] rxHead,
	input uartPkg::fifoStatus_t rxStat,
	input uartPkg::fifoStatus_t txStat,
	output logic rxPop,
	output logic txPush,
	output logic [uartPkg::dataBits-1:0] txPushData
);

	logic wrReady;                  // awReady and wReady together
	logic rdReady;
	logic bValid;
	logic rValid;
	logic wrXfer;                   // address and data taken this edge
	logic rdXfer;
	logic clearHit;
	logic rxOverrun;                // byte lost on a full rx fifo
	axiLitePkg::axiResp_t wrResp;   // decoded, captured on transfer
	axiLitePkg::axiResp_t rdResp;
	axiLitePkg::axiResp_t bResp;
	axiLitePkg::axiResp_t rResp;
	logic [31:0] rdWord;
	logic [31:0] rData;
	uartPkg::uartStatus_t status;

	assign wrXfer = wrReady && busReq.awValid && busReq.wValid;
	assign rdXfer = rdReady && busReq.arValid;

	assign status.rxEmpty = rxStat.empty;
	assign status.rxFull = rxStat.full;
	assign status.txEmpty = txStat.empty;
	assign status.txFull = txStat.full;
	assign status.rxOverrun = rxOverrun;

	//////////////////////////////
	// address decode
	//////////////////////////////

	always_comb
	begin
		txPush = 1'b0;
		clearHit = 1'b0;
		wrResp = axiLitePkg::respSlvErr;
		case (busReq.awAddr)
			uartPkg::regData:
			begin
				txPush = wrXfer && !txStat.full;
				if (!txStat.full)
					wrResp = axiLitePkg::respOkay;
			end
			uartPkg::regClear:
			begin
				clearHit = wrXfer;
				wrResp = axiLitePkg::respOkay;
			end
			default:
				wrResp = axiLitePkg::respSlvErr;   // status is read only
		endcase
	end

	assign txPushData = busReq.wData[uartPkg::dataBits-1:0];

	always_comb
	begin
		rxPop = 1'b0;
		rdWord = '0;
		rdResp = axiLitePkg::respSlvErr;
		case (busReq.arAddr)
			uartPkg::regData:
				if (!rxStat.empty)
				begin
					rxPop = rdXfer;
					rdWord = 32'(rxHead);
					rdResp = axiLitePkg::respOkay;
				end
			uartPkg::regStatus:
			begin
				rdWord = 32'(status);
				rdResp = axiLitePkg::respOkay;
			end
			default:
				rdWord = '0;
		endcase
	end

	//////////////////////////////
	// handshake and flags
	//////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrReady <= 1'b0;
			rdReady <= 1'b0;
			bValid <= 1'b0;
			rValid <= 1'b0;
			rxOverrun <= 1'b0;
		end
		else
		begin
			// one-cycle ready, held off while a response waits
			wrReady <= busReq.awValid && busReq.wValid && !wrReady && !bValid;
			rdReady <= busReq.arValid && !rdReady && !rValid;
			if (wrXfer)
				bValid <= 1'b1;
			else if (busReq.bReady)
				bValid <= 1'b0;
			if (rdXfer)
				rValid <= 1'b1;
			else if (busReq.rReady)
				rValid <= 1'b0;
			if (rxDone && rxStat.full)
				rxOverrun <= 1'b1;   // a new loss beats a clear
			else if (clearHit)
				rxOverrun <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wrXfer)
			bResp <= wrResp;
		if (rdXfer)
		begin
			rResp <= rdResp;
			rData <= rdWord;   // head before the pop lands
		end
	end

	assign busRsp.awReady = wrReady;
	assign busRsp.wReady = wrReady;
	assign busRsp.bValid = bValid;
	assign busRsp.bResp = bResp;
	assign busRsp.arReady = rdReady;
	assign busRsp.rValid = rValid;
	assign busRsp.rData = rData;
	assign busRsp.rResp = rResp;

	// responses hold under back-pressure
	assert property (@(posedge clk) disable iff (reset)
		bValid && !busReq.bReady |=> bValid && $stable(bResp));
	assert property (@(posedge clk) disable iff (reset)
		rValid && !busReq.rReady |=> rValid && $stable(rData) && $stable(rResp));

endmodule

`default_nettype wire

/* design/uartTop.sv */
`timescale 1ns/100ps
`default_nettype none

module uartTop
#(
	parameter int baudDivisor = 4,   // clk cycles per oversampling tick
	parameter int fifoDepth = 16
)
(
	input logic clk,
	input logic reset,
	input axiLitePkg::axiLiteReq_t busReq,
	output axiLitePkg::axiLiteRsp_t busRsp,
	input logic rx,
	output logic tx
);

	logic sTick;
	logic rxDoneTick;
	logic [uartPkg::dataBits-1:0] rxByte;       // receiver to rx fifo
	logic [uartPkg::dataBits-1:0] rxHead;
	logic [uartPkg::dataBits-1:0] txHead;
	logic [uartPkg::dataBits-1:0] txPushData;
	uartPkg::fifoStatus_t rxStat;
	uartPkg::fifoStatus_t txStat;
	logic rxPop;
	logic txPush;
	logic txPop;
	logic txStart;

	assign txStart = !txStat.empty;   // any queued byte starts a frame

	baudTickGen #(.baudDivisor(baudDivisor)) i_tickGen
		(.clk(clk), .reset(reset), .sTick(sTick));

	uartRec i_rec
		(.clk(clk), .reset(reset), .sTick(sTick), .rx(rx),
		.rxDoneTick(rxDoneTick), .dOut(rxByte));

	uartFifo #(.fifoDepth(fifoDepth)) i_rxFifo
		(.clk(clk), .reset(reset), .push(rxDoneTick), .pop(rxPop),
		.pushData(rxByte), .headData(rxHead), .status(rxStat));

	uartFifo #(.fifoDepth(fifoDepth)) i_txFifo
		(.clk(clk), .reset(reset), .push(txPush), .pop(txPop),
		.pushData(txPushData), .headData(txHead), .status(txStat));

	uartXmit i_xmit
		(.clk(clk), .reset(reset), .sTick(sTick), .txStart(txStart), .txData(txHead),
		.txReady(), .txPop(txPop), .tx(tx));

	uartAxiRegs i_regs
		(.clk(clk), .reset(reset), .rxDone(rxDoneTick), .busReq(busReq), .busRsp(busRsp),
		.rxHead(rxHead), .rxStat(rxStat), .txStat(txStat), .rxPop(rxPop),
		.txPush(txPush), .txPushData(txPushData));

endmodule

`default_nettype wire

/* dv/uartTb.sv */
`timescale 1ns/100ps
`default_nettype none

module uartTb;

	localparam int clkPerBit = 4 * 16;            // baudDivisor x oversampling
	localparam int maxCycles = 20 * 700 + 2000;   // 20 frames plus bus traffic

	logic clk;
	logic reset;
	logic rx;
	logic tx;
	axiLitePkg::axiLiteReq_t busReq;
	axiLitePkg::axiLiteRsp_t busRsp;

	int seed = 27722;
	int errCount = 0;
	int checkCount = 0;
	int cycleCount = 0;

	logic [7:0] rxModel[$];      // bytes sent on rx, not yet read back
	logic [7:0] expTx[$];        // bytes accepted for tx, in order
	logic [9:0] seenFrames[$];   // line samples from the monitor

	uartTop #(.baudDivisor(4), .fifoDepth(4)) i_dut
		(.clk(clk), .reset(reset), .busReq(busReq), .busRsp(busRsp), .rx(rx), .tx(tx));

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//////////////////////////////
	// reference and helpers
	//////////////////////////////

	// line level per bit time with the start bit at index 0
	function automatic logic [9:0] frameBits(input logic [7:0] b);
		logic [9:0] f;
		f[0] = 1'b0;
		for (int i = 0; i < 8; i++)
			f[i + 1] = b[i];   // LSB first
		f[9] = 1'b1;           // stop
		return f;
	endfunction

	function automatic logic [31:0] statusWord(input logic rxE, input logic rxF,
		input logic txE, input logic txF, input logic ovr);
		uartPkg::uartStatus_t st;
		st.rxEmpty = rxE;
		st.rxFull = rxF;
		st.txEmpty = txE;
		st.txFull = txF;
		st.rxOverrun = ovr;
		return 32'(st);
	endfunction

	task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		assert (got === exp)
		else
		begin
			errCount++;
			$display("[ERROR] %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// entered and left at posedge + 2
	task automatic writeReg(input logic [3:0] addr, input logic [31:0] data, input int stall,
		output axiLitePkg::axiResp_t resp);
		busReq.awValid = 1'b1;
		busReq.awAddr = addr;
		busReq.wValid = 1'b1;
		busReq.wData = data;
		busReq.wStrb = 4'hf;
		do
			@(negedge clk);
		while (busRsp.awReady !== 1'b1);
		checkValue("wReady with awReady", busRsp.wReady, 1'b1);
		@(posedge clk);   // transfer edge
		#2;
		busReq.awValid = 1'b0;
		busReq.wValid = 1'b0;
		@(negedge clk);
		checkValue("awReady after accept", busRsp.awReady, 1'b0);
		checkValue("wReady after accept", busRsp.wReady, 1'b0);
		checkValue("bValid one cycle after accept", busRsp.bValid, 1'b1);
		resp = busRsp.bResp;
		repeat (stall)
		begin
			@(negedge clk);
			checkValue("bValid under stall", busRsp.bValid, 1'b1);
			checkValue("bResp under stall", busRsp.bResp, resp);
		end
		@(posedge clk);
		#2;
		busReq.bReady = 1'b1;
		@(posedge clk);
		#2;
		busReq.bReady = 1'b0;
		checkValue("bValid after bReady", busRsp.bValid, 1'b0);
	endtask

	task automatic readReg(input logic [3:0] addr, input int stall,
		output logic [31:0] data, output axiLitePkg::axiResp_t resp);
		busReq.arValid = 1'b1;
		busReq.arAddr = addr;
		do
			@(negedge clk);
		while (busRsp.arReady !== 1'b1);
		@(posedge clk);
		#2;
		busReq.arValid = 1'b0;
		@(negedge clk);
		checkValue("arReady after accept", busRsp.arReady, 1'b0);
		checkValue("rValid one cycle after accept", busRsp.rValid, 1'b1);
		data = busRsp.rData;
		resp = busRsp.rResp;
		repeat (stall)
		begin
			@(negedge clk);
			checkValue("rValid under stall", busRsp.rValid, 1'b1);
			checkValue("rData under stall", busRsp.rData, data);
			checkValue("rResp under stall", busRsp.rResp, resp);
		end
		@(posedge clk);
		#2;
		busReq.rReady = 1'b1;
		@(posedge clk);
		#2;
		busReq.rReady = 1'b0;
		checkValue("rValid after rReady", busRsp.rValid, 1'b0);
	endtask

	task automatic sendFrame(input logic [7:0] b);
		logic [9:0] f;
		f = frameBits(b);
		for (int i = 0; i < 10; i++)
		begin
			rx = f[i];
			repeat (clkPerBit) @(posedge clk);
			#2;
		end
		rxModel.push_back(b);
	endtask

	//////////////////////////////
	// tx monitor and compare
	//////////////////////////////

	initial
	begin : txMonitor
		logic [9:0] bits;
		wait (reset === 1'b0);
		forever
		begin
			@(negedge clk);
			if (tx === 1'b0)
			begin
				repeat (clkPerBit / 2 - 1) @(negedge clk);   // middle of start bit
				for (int i = 0; i < 10; i++)
				begin
					bits[i] = tx;
					if (i < 9)
						repeat (clkPerBit) @(negedge clk);
				end
				seenFrames.push_back(bits);
			end
		end
	end

	initial
	begin : frameCompare
		logic [9:0] got;
		forever
		begin
			wait (seenFrames.size() > 0);
			got = seenFrames.pop_front();
			checkCount++;
			assert (expTx.size() > 0)
			else
			begin
				errCount++;
				$display("a frame appeared on tx although no byte was queued for it");
			end
			if (expTx.size() > 0)
				checkValue("tx frame", got, frameBits(expTx.pop_front()));
		end
	end

	// run limit
	initial
	begin
		while (cycleCount < maxCycles)
		begin
			@(posedge clk);
			cycleCount++;
		end
		errCount++;
		$display("timeout: run did not finish within %0d cycles", maxCycles);
		$display("%0d checks, %0d errors", checkCount, errCount);
		$display("Errors found");
		$finish;
	end

	//////////////////////////////
	// stimulus
	//////////////////////////////

	initial
	begin : stimulus
		logic [31:0] data;
		axiLitePkg::axiResp_t resp;
		logic [7:0] b;
		reset = 1'b1;
		rx = 1'b1;
		busReq = '0;
		repeat (10) @(posedge clk);
		#2;
		reset = 1'b0;

		// idle state after reset
		checkValue("tx after reset", tx, 1'b1);
		checkValue("ready and valid after reset",
			{busRsp.awReady, busRsp.wReady, busRsp.bValid, busRsp.arReady, busRsp.rValid},
			5'b0);
		readReg(uartPkg::regStatus, 0, data, resp);
		checkValue("status after reset", data, statusWord(1, 0, 1, 0, 0));
		checkValue("status resp", resp, axiLitePkg::respOkay);

		// eight bytes in over two fills of the rx fifo
		repeat (2)
		begin
			repeat (4)
				sendFrame(8'($random(seed)));
			repeat (4)
			begin
				readReg(uartPkg::regData, 0, data, resp);
				checkValue("rx byte", data, 32'(rxModel.pop_front()));
				checkValue("rx read resp", resp, axiLitePkg::respOkay);
			end
		end

		// five bytes fill shifter and fifo and a sixth is refused
		repeat (5)
		begin
			b = 8'($random(seed));
			expTx.push_back(b);
			writeReg(uartPkg::regData, 32'(b), 0, resp);
			checkValue("tx write resp", resp, axiLitePkg::respOkay);
		end
		writeReg(uartPkg::regData, 32'h5a, 0, resp);
		checkValue("write to full tx fifo", resp, axiLitePkg::respSlvErr);
		readReg(uartPkg::regStatus, 0, data, resp);
		checkValue("status tx full", data, statusWord(1, 0, 0, 1, 0));
		wait (expTx.size() == 0);
		@(posedge clk);
		#2;

		// overrun on a full rx fifo
		repeat (5)
			sendFrame(8'($random(seed)));
		void'(rxModel.pop_back());   // fifth byte is dropped
		readReg(uartPkg::regStatus, 0, data, resp);
		checkValue("status overrun", data, statusWord(0, 1, 1, 0, 1));
		writeReg(uartPkg::regClear, 32'h0, 0, resp);
		checkValue("clear resp", resp, axiLitePkg::respOkay);
		readReg(uartPkg::regStatus, 0, data, resp);
		checkValue("status after clear", data, statusWord(0, 1, 1, 0, 0));
		repeat (4)
		begin
			readReg(uartPkg::regData, 0, data, resp);
			checkValue("stored rx byte", data, 32'(rxModel.pop_front()));
			checkValue("stored rx resp", resp, axiLitePkg::respOkay);
		end

		// error responses
		readReg(uartPkg::regData, 0, data, resp);
		checkValue("empty rx data", data, 32'h0);
		checkValue("empty rx resp", resp, axiLitePkg::respSlvErr);
		readReg(4'hc, 0, data, resp);
		checkValue("unmapped data", data, 32'h0);
		checkValue("unmapped resp", resp, axiLitePkg::respSlvErr);

		// back-pressure on both response channels
		readReg(uartPkg::regStatus, 6, data, resp);
		checkValue("stalled status", data, statusWord(1, 0, 1, 0, 0));
		writeReg(uartPkg::regClear, 32'h1, 6, resp);
		checkValue("stalled clear resp", resp, axiLitePkg::respOkay);

		repeat (10) @(posedge clk);
		$display("%0d checks, %0d errors", checkCount, errCount);
		if (errCount == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
design/uartPkg.sv
design/axiLitePkg.sv
design/baudTickGen.sv
design/uartRec.sv
design/uartXmit.sv
design/uartFifo.sv
design/uartAxiRegs.sv
design/uartTop.sv
dv/uartTb.sv
